// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

    // datapath width
    parameter int XLEN = 32;

    //////////////////////////////////////////////////
    // instruction word, two layouts of the same bits
    //////////////////////////////////////////////////

    typedef union packed {
        // register-register layout
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        // register-immediate layout
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_t;

    // major opcodes in the subset
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_LUI    = 7'b0110111;

    // funct3 codes
    parameter logic [2:0] F3_ADD_SUB = 3'b000;
    parameter logic [2:0] F3_SLL     = 3'b001;
    parameter logic [2:0] F3_SLT     = 3'b010;
    parameter logic [2:0] F3_SLTU    = 3'b011;
    parameter logic [2:0] F3_XOR     = 3'b100;
    parameter logic [2:0] F3_SRL_SRA = 3'b101;
    parameter logic [2:0] F3_OR      = 3'b110;
    parameter logic [2:0] F3_AND     = 3'b111;

    // funct7 codes, alt picks sub and sra
    parameter logic [6:0] F7_BASE = 7'b0000000;
    parameter logic [6:0] F7_ALT  = 7'b0100000;

    //////////////////////////////////////////////////
    // alu operation codes
    //////////////////////////////////////////////////

    parameter logic [3:0] ALU_ADD    = 4'd0;
    parameter logic [3:0] ALU_SUB    = 4'd1;
    parameter logic [3:0] ALU_AND    = 4'd2;
    parameter logic [3:0] ALU_OR     = 4'd3;
    parameter logic [3:0] ALU_XOR    = 4'd4;
    parameter logic [3:0] ALU_SLL    = 4'd5;
    parameter logic [3:0] ALU_SRL    = 4'd6;
    parameter logic [3:0] ALU_SRA    = 4'd7;
    parameter logic [3:0] ALU_SLT    = 4'd8;
    parameter logic [3:0] ALU_SLTU   = 4'd9;
    // lui result is operand b as is
    parameter logic [3:0] ALU_PASS_B = 4'd10;

endpackage

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file import core_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic [4:0]      rs1_addr,
    input  wire logic [4:0]      rs2_addr,
    input  wire logic [4:0]      debug_addr,
    input  wire logic            wr_en,
    input  wire logic [4:0]      wr_addr,
    input  wire logic [XLEN-1:0] wr_data,
    output logic      [XLEN-1:0] rs1_data,
    output logic      [XLEN-1:0] rs2_data,
    output logic      [XLEN-1:0] debug_data
);

    // full span of a 5 bit index
    localparam int IDX_SPAN = 32;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];
    // every index, with x0 and missing regs reading zero
    logic [XLEN-1:0] view [IDX_SPAN];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0 && int'(wr_addr) < NUM_REGS) begin
            regs[wr_addr] <= wr_data;
        end
    end

    for (genvar g = 0; g < IDX_SPAN; g++) begin : g_view
        if (g == 0 || g >= NUM_REGS) begin : g_zero
            assign view[g] = '0;
        end else begin : g_reg
            assign view[g] = regs[g];
        end
    end

    // combinational read ports
    assign rs1_data   = view[rs1_addr];
    assign rs2_data   = view[rs2_addr];
    assign debug_data = view[debug_addr];

endmodule

`default_nettype wire

// File: source/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode import core_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            instr_valid,
    input  wire instr_t          instr,
    input  wire logic [XLEN-1:0] rs1_data,
    input  wire logic [XLEN-1:0] rs2_data,
    output logic      [4:0]      rs1_addr,
    output logic      [4:0]      rs2_addr,
    output logic                 dec_valid,
    output logic      [4:0]      dec_rd,
    output logic      [4:0]      dec_rs1,
    output logic      [4:0]      dec_rs2,
    output logic      [XLEN-1:0] dec_op_a,
    output logic      [XLEN-1:0] dec_op_b,
    output logic                 dec_use_imm,
    output logic      [XLEN-1:0] dec_imm,
    output logic      [3:0]      dec_alu_op,
    output logic                 dec_illegal
);

    logic            is_op;
    logic            is_op_imm;
    logic            is_lui;
    logic            alt;
    logic            enc_ok;
    logic            idx_ok;
    logic [4:0]      src1;
    logic [4:0]      src2;
    logic [XLEN-1:0] imm;
    logic [3:0]      alu_op;

    assign is_op     = instr.r.opcode == OPC_OP;
    assign is_op_imm = instr.r.opcode == OPC_OP_IMM;
    assign is_lui    = instr.r.opcode == OPC_LUI;
    // bit 30 in both layouts
    assign alt       = instr.r.funct7 == F7_ALT;

    //////////////////////////////////////////////////
    // encoding check
    //////////////////////////////////////////////////

    always_comb begin
        enc_ok = 1'b0;
        if (is_op) begin
            // alt form only for sub and sra
            enc_ok = instr.r.funct7 == F7_BASE ||
                     (alt && (instr.r.funct3 == F3_ADD_SUB ||
                              instr.r.funct3 == F3_SRL_SRA));
        end else if (is_op_imm) begin
            if (instr.r.funct3 == F3_SLL) begin
                enc_ok = instr.r.funct7 == F7_BASE;
            end else if (instr.r.funct3 == F3_SRL_SRA) begin
                enc_ok = instr.r.funct7 == F7_BASE || alt;
            end else begin
                // plain immediate, any value
                enc_ok = 1'b1;
            end
        end else if (is_lui) begin
            enc_ok = 1'b1;
        end
    end

    // lui has no rs1, only r-type has rs2
    assign src1 = is_lui ? 5'd0 : instr.i.rs1;
    assign src2 = is_op ? instr.r.rs2 : 5'd0;
    assign rs1_addr = src1;
    assign rs2_addr = src2;

    // rv32e leaves the upper half of the index space empty
    assign idx_ok = int'(instr.r.rd) < NUM_REGS && int'(src1) < NUM_REGS &&
                    int'(src2) < NUM_REGS;

    // u immediate or sign extended i immediate
    assign imm = is_lui ? {instr[31:12], 12'h000} :
                          {{(XLEN-12){instr.i.imm[11]}}, instr.i.imm};

    // alu op from funct3, alt bit for sub only on r-type
    always_comb begin
        case (instr.r.funct3)
            F3_ADD_SUB: alu_op = (is_op && alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_op = ALU_SLL;
            F3_SLT:     alu_op = ALU_SLT;
            F3_SLTU:    alu_op = ALU_SLTU;
            F3_XOR:     alu_op = ALU_XOR;
            F3_SRL_SRA: alu_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_op = ALU_OR;
            default:    alu_op = ALU_AND;
        endcase
        if (is_lui) begin
            alu_op = ALU_PASS_B;
        end
    end

    //////////////////////////////////////////////////
    // decode registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid   <= 1'b0;
            dec_illegal <= 1'b0;
            dec_rd      <= '0;
            dec_rs1     <= '0;
            dec_rs2     <= '0;
            dec_op_a    <= '0;
            dec_op_b    <= '0;
            dec_use_imm <= 1'b0;
            dec_imm     <= '0;
            dec_alu_op  <= ALU_ADD;
        end else begin
            dec_valid   <= instr_valid;
            dec_illegal <= instr_valid && !(enc_ok && idx_ok);
            if (instr_valid) begin
                dec_rd      <= instr.r.rd;
                dec_rs1     <= src1;
                dec_rs2     <= src2;
                // may be stale, execute forwards over these
                dec_op_a    <= rs1_data;
                dec_op_b    <= rs2_data;
                dec_use_imm <= is_op_imm || is_lui;
                dec_imm     <= imm;
                dec_alu_op  <= alu_op;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/alu_execute.sv
`timescale 1ns/1ns
`default_nettype none

module alu_execute import core_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            dec_valid,
    input  wire logic [4:0]      dec_rd,
    input  wire logic [4:0]      dec_rs1,
    input  wire logic [4:0]      dec_rs2,
    input  wire logic [XLEN-1:0] dec_op_a,
    input  wire logic [XLEN-1:0] dec_op_b,
    input  wire logic            dec_use_imm,
    input  wire logic [XLEN-1:0] dec_imm,
    input  wire logic [3:0]      dec_alu_op,
    input  wire logic            dec_illegal,
    input  wire logic            retire_valid,
    input  wire logic [4:0]      retire_rd,
    input  wire logic [XLEN-1:0] retire_data,
    output logic                 ex_valid,
    output logic      [4:0]      ex_rd,
    output logic      [XLEN-1:0] ex_result,
    output logic                 ex_illegal
);

    logic            ex_fwd_ok;
    logic            rt_fwd_ok;
    // legal flag of whatever sits in the retire registers
    logic            rt_legal;
    logic            hit_ex_a;
    logic            hit_rt_a;
    logic            hit_ex_b;
    logic            hit_rt_b;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] src_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_out;

    //////////////////////////////////////////////////
    // forwarding, one ahead wins over two ahead
    //////////////////////////////////////////////////

    assign ex_fwd_ok = ex_valid && !ex_illegal;
    assign rt_fwd_ok = retire_valid && rt_legal;

    // x0 never forwarded
    assign hit_ex_a = ex_fwd_ok && dec_rs1 != 5'd0 && ex_rd == dec_rs1;
    assign hit_rt_a = rt_fwd_ok && dec_rs1 != 5'd0 && retire_rd == dec_rs1;
    assign hit_ex_b = ex_fwd_ok && dec_rs2 != 5'd0 && ex_rd == dec_rs2;
    assign hit_rt_b = rt_fwd_ok && dec_rs2 != 5'd0 && retire_rd == dec_rs2;

    assign op_a = hit_ex_a ? ex_result : hit_rt_a ? retire_data : dec_op_a;
    assign op_b = hit_ex_b ? ex_result : hit_rt_b ? retire_data : dec_op_b;

    // immediate replaces rs2 on i-type and lui
    assign src_b = dec_use_imm ? dec_imm : op_b;
    assign shamt = src_b[4:0];

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////

    always_comb begin
        case (dec_alu_op)
            ALU_ADD:    alu_out = op_a + src_b;
            ALU_SUB:    alu_out = op_a - src_b;
            ALU_AND:    alu_out = op_a & src_b;
            ALU_OR:     alu_out = op_a | src_b;
            ALU_XOR:    alu_out = op_a ^ src_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(src_b)};
            ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, op_a < src_b};
            ALU_PASS_B: alu_out = src_b;
            default:    alu_out = '0;
        endcase
    end

    // execute output registers
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid   <= 1'b0;
            ex_illegal <= 1'b0;
            ex_rd      <= '0;
            ex_result  <= '0;
            rt_legal   <= 1'b0;
        end else begin
            ex_valid   <= dec_valid;
            ex_illegal <= dec_valid && dec_illegal;
            // tracks the retire registers one stage on
            rt_legal   <= ex_valid && !ex_illegal;
            if (dec_valid) begin
                ex_rd     <= dec_rd;
                ex_result <= alu_out;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/result_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module result_writeback import core_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            ex_valid,
    input  wire logic [4:0]      ex_rd,
    input  wire logic [XLEN-1:0] ex_result,
    input  wire logic            ex_illegal,
    output logic                 wr_en,
    output logic      [4:0]      wr_addr,
    output logic      [XLEN-1:0] wr_data,
    output logic                 retire_valid,
    output logic      [4:0]      retire_rd,
    output logic      [XLEN-1:0] retire_data,
    output logic                 retire_illegal
);

    //////////////////////////////////////////////////
    // register file write, same edge as retire
    //////////////////////////////////////////////////

    // x0 and illegal items never write
    assign wr_en   = ex_valid && !ex_illegal && ex_rd != 5'd0;
    assign wr_addr = ex_rd;
    assign wr_data = ex_result;

    // retire port
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid   <= 1'b0;
            retire_illegal <= 1'b0;
            retire_rd      <= '0;
            retire_data    <= '0;
        end else begin
            retire_valid   <= ex_valid;
            retire_illegal <= ex_valid && ex_illegal;
            if (ex_valid) begin
                retire_rd <= ex_rd;
                // illegal retires with zero data
                retire_data <= ex_illegal ? '0 : ex_result;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mini_core.sv
`timescale 1ns/1ns
`default_nettype none

module mini_core import core_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            instr_valid,
    input  wire instr_t          instr,
    input  wire logic [4:0]      debug_addr,
    output logic                 retire_valid,
    output logic      [4:0]      retire_rd,
    output logic      [XLEN-1:0] retire_data,
    output logic                 retire_illegal,
    output logic      [XLEN-1:0] debug_data
);

    // decode to register file
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    // decode to execute
    logic            dec_valid;
    logic [4:0]      dec_rd;
    logic [4:0]      dec_rs1;
    logic [4:0]      dec_rs2;
    logic [XLEN-1:0] dec_op_a;
    logic [XLEN-1:0] dec_op_b;
    logic            dec_use_imm;
    logic [XLEN-1:0] dec_imm;
    logic [3:0]      dec_alu_op;
    logic            dec_illegal;

    // execute to result
    logic            ex_valid;
    logic [4:0]      ex_rd;
    logic [XLEN-1:0] ex_result;
    logic            ex_illegal;

    // result to register file
    logic            wr_en;
    logic [4:0]      wr_addr;
    logic [XLEN-1:0] wr_data;

    //////////////////////////////////////////////////
    // stages
    //////////////////////////////////////////////////

    reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (.*);

    instr_decode #(.NUM_REGS(NUM_REGS)) u_decode (.*);

    // retire registers double as second forwarding source
    alu_execute u_execute (.*);

    result_writeback u_result (.*);

endmodule

`default_nettype wire

// File: sim/core_sva.sv
`timescale 1ns/1ns
`default_nettype none

module core_sva (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       instr_valid,
    input wire logic       retire_valid,
    input wire logic       retire_illegal,
    input wire logic       wr_en,
    input wire logic [4:0] wr_addr
);

    // failed assertions, read by the testbench at the end
    int violations = 0;

    //////////////////////////////////////////////////
    // pipeline timing
    //////////////////////////////////////////////////

    // three stages, no stalls
    retire_after_issue: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> ##3 retire_valid)
    else begin
        $error("instruction did not retire three cycles after issue");
        violations++;
    end

    // nothing retires without an issue three cycles back
    issue_before_retire: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> $past(instr_valid, 3))
    else begin
        $error("retire without a matching issue");
        violations++;
    end

    // write rules
    illegal_needs_valid: assert property (@(posedge clk) disable iff (rst)
        retire_illegal |-> retire_valid)
    else begin
        $error("retire_illegal high without retire_valid");
        violations++;
    end

    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        !(wr_en && wr_addr == 5'd0))
    else begin
        $error("register file write to x0");
        violations++;
    end

endmodule

bind mini_core core_sva u_sva (.*);

`default_nettype wire

// File: sim/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb import core_pkg::*; ;

    localparam int NUM_REGS     = 32;
    localparam int RST_CYCLES   = 8;
    localparam int N_RR         = 200;
    localparam int N_RI         = 150;
    localparam int MAX_GAP      = 3;
    localparam int N_DIRECTED   = 40;
    localparam int DRAIN_CYCLES = 10;
    // reset, two debug sweeps, all tests at worst case spacing, drains
    localparam int CYCLE_LIMIT  = RST_CYCLES + 2 * NUM_REGS + N_RR + N_RI * (MAX_GAP + 1) +
                                  N_DIRECTED + 5 * DRAIN_CYCLES + 100;

    logic            clk = 1'b0;
    logic            rst;
    logic            instr_valid;
    logic [31:0]     instr_word;
    logic [4:0]      debug_addr;
    logic            retire_valid;
    logic [4:0]      retire_rd;
    logic [XLEN-1:0] retire_data;
    logic            retire_illegal;
    logic [XLEN-1:0] debug_data;

    // model state written in issue order
    logic [31:0] model_regs [NUM_REGS];
    // expected {illegal, rd, data} per issued instruction
    logic [37:0] exp_q [$];
    logic [37:0] retired_exp;
    logic [15:0] lfsr_state = 16'd6925;
    int          checks = 0;
    int          errors = 0;
    int          mark_checks;
    int          mark_errors;
    int          cycles = 0;
    logic [4:0]  gap;

    always #4 clk = ~clk;

    mini_core #(.NUM_REGS(NUM_REGS)) u_dut (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr_word),
        .debug_addr(debug_addr), .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_data(retire_data), .retire_illegal(retire_illegal), .debug_data(debug_data)
    );

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    // mostly x0..x7 so results feed each other
    function automatic logic [4:0] pick_reg();
        if (rand_bits(2) == 32'd0) begin
            return 5'(rand_bits(5));
        end
        return 5'(rand_bits(3));
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] rand_rtype();
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = 3'(rand_bits(3));
        // alt form only where it exists
        f7 = ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && rand_bits(1) != 0) ? F7_ALT : F7_BASE;
        return enc_r(f7, pick_reg(), pick_reg(), f3, pick_reg());
    endfunction

    function automatic logic [31:0] rand_itype();
        logic [2:0]  f3;
        logic [11:0] imm;
        if (rand_bits(2) == 32'd0) begin
            return enc_u(20'(rand_bits(20)), pick_reg());
        end
        f3 = 3'(rand_bits(3));
        if (f3 == F3_SLL) begin
            imm = {7'd0, 5'(rand_bits(5))};
        end else if (f3 == F3_SRL_SRA) begin
            // srli or srai
            imm = {(rand_bits(1) != 0) ? F7_ALT : F7_BASE, 5'(rand_bits(5))};
        end else begin
            imm = 12'(rand_bits(12));
        end
        return enc_i(imm, pick_reg(), f3, pick_reg());
    endfunction

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    function automatic logic [37:0] ref_result(input logic [31:0] w);
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic        legal;
        opc = w[6:0];
        rd  = w[11:7];
        f3  = w[14:12];
        f7  = w[31:25];
        // lui reads no register
        a   = (opc == OPC_LUI) ? 32'd0 : model_regs[w[19:15]];
        case (opc)
            OPC_OP:     b = model_regs[w[24:20]];
            OPC_LUI:    b = {w[31:12], 12'd0};
            default:    b = {{20{w[31]}}, w[31:20]};
        endcase
        case (opc)
            OPC_OP:     legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            OPC_OP_IMM: legal = (f3 == 3'd1) ? f7 == 7'h00 :
                                (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
            OPC_LUI:    legal = 1'b1;
            default:    legal = 1'b0;
        endcase
        case (f3)
            3'd0:    d = (opc == OPC_OP && f7[5]) ? a - b : a + b;
            3'd1:    d = a << b[4:0];
            3'd2:    d = {31'd0, $signed(a) < $signed(b)};
            3'd3:    d = {31'd0, a < b};
            3'd4:    d = a ^ b;
            3'd5:    d = f7[5] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    d = a | b;
            default: d = a & b;
        endcase
        if (opc == OPC_LUI) begin
            d = b;
        end
        if (!legal) begin
            d = 32'd0;
        end
        return {!legal, rd, d};
    endfunction

    //////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
        checks++;
        assert (expv === actv) else begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, expv, actv);
            errors++;
        end
    endtask

    // retire outputs settle well before posedge plus 2
    always @(posedge clk) begin
        #2;
        if (!rst && retire_valid) begin
            if (exp_q.size() == 0) begin
                $display("retire at %0t with no instruction outstanding", $time);
                errors++;
            end else begin
                retired_exp = exp_q.pop_front();
                compare_value("retire_rd", 32'(retired_exp[36:32]), 32'(retire_rd));
                compare_value("retire_data", retired_exp[31:0], retire_data);
                compare_value("retire_illegal", 32'(retired_exp[37]), 32'(retire_illegal));
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d retires pending", cycles, exp_q.size());
            $display("sim failed");
            $finish;
        end
    end

    task automatic issue(input logic [31:0] w);
        logic [37:0] e;
        @(negedge clk);
        e = ref_result(w);
        instr_valid = 1'b1;
        instr_word  = w;
        exp_q.push_back(e);
        // legal writes to x1..x31 only
        if (!e[37] && e[36:32] != 5'd0) begin
            model_regs[e[36:32]] = e[31:0];
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int n;
        idle(1);
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d instructions never retired", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic read_debug(input logic [4:0] idx, input logic [31:0] expv);
        @(negedge clk);
        debug_addr = idx;
        #1;
        compare_value("debug_data", expv, debug_data);
    endtask

    task automatic begin_test();
        mark_checks = checks;
        mark_errors = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %s %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr_word  = '0;
        debug_addr  = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset state
        begin_test();
        compare_value("retire_valid", 32'd0, 32'(retire_valid));
        for (int i = 0; i < NUM_REGS; i++) begin
            read_debug(5'(i), 32'd0);
        end
        end_test("reset");

        // dependent r-type back to back
        begin_test();
        for (int i = 0; i < N_RR; i++) begin
            issue(rand_rtype());
        end
        wait_drain();
        end_test("r-type");

        // i-type and lui with idle gaps, then srai and sltiu corners
        begin_test();
        for (int i = 0; i < N_RI; i++) begin
            issue(rand_itype());
            gap = 5'(rand_bits(2));
            idle(int'(gap));
        end
        issue(enc_u(20'h80000, 5'd4));
        issue(enc_i(12'h404, 5'd4, F3_SRL_SRA, 5'd5));
        issue(enc_i(12'hFFF, 5'd5, F3_SLTU, 5'd6));
        issue(enc_i(12'h800, 5'd0, F3_ADD_SUB, 5'd7));
        wait_drain();
        end_test("i-type");

        // x0 destination, then x0 as an operand right behind it
        begin_test();
        issue(enc_i(12'd123, 5'd0, F3_ADD_SUB, 5'd0));
        issue(enc_u(20'hABCDE, 5'd0));
        issue(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd0));
        issue(enc_r(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd7));
        issue(enc_i(12'd5, 5'd0, F3_ADD_SUB, 5'd6));
        wait_drain();
        read_debug(5'd0, 32'd0);
        end_test("x0 target");

        // load, mul, alt xor, alt slli, jal
        begin_test();
        issue({12'h000, 5'd1, 3'b010, 5'd3, 7'b0000011});
        issue(enc_r(7'h01, 5'd2, 5'd1, F3_ADD_SUB, 5'd2));
        issue(enc_r(F7_ALT, 5'd3, 5'd1, F3_XOR, 5'd4));
        issue(enc_i(12'h402, 5'd1, F3_SLL, 5'd5));
        issue({20'h00010, 5'd6, 7'b1101111});
        // legal reader of the two illegal writers still in flight
        issue(enc_r(F7_BASE, 5'd6, 5'd5, F3_ADD_SUB, 5'd7));
        wait_drain();
        for (int i = 2; i <= 7; i++) begin
            read_debug(5'(i), model_regs[i]);
        end
        end_test("illegal");

        // final register sweep
        begin_test();
        for (int i = 0; i < NUM_REGS; i++) begin
            read_debug(5'(i), model_regs[i]);
        end
        end_test("final state");

        if (u_dut.u_sva.violations != 0) begin
            $display("%0d bound assertion violations", u_dut.u_sva.violations);
            errors += u_dut.u_sva.violations;
        end
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
source/core_pkg.sv
source/reg_file.sv
source/instr_decode.sv
source/alu_execute.sv
source/result_writeback.sv
source/mini_core.sv
sim/core_sva.sv
sim/core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module core_tb -f sim.f \
    --Mdir obj_dir -o core_tb_sim

# keep running past assertion errors so the testbench reports them
./obj_dir/core_tb_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1
